// ==== core_reply_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_reply_mux
	import user_io_pkg::*;
#(
	parameter int STRLEN = 1
)(
	input  logic [8*STRLEN-1:0] conf_str_i,
	spi_byte_if.reply           bus
);

	localparam int SEL_W = (STRLEN > 1) ? $clog2(STRLEN) : 1;

	byte_t            conf_chr [STRLEN];
	logic [SEL_W-1:0] chr_sel;
	logic             in_str;

	// ========================================================================
	// configuration string as characters
	// ========================================================================

	// leftmost character sits in the top byte of the string
	for (genvar i = 0; i < STRLEN; i++) begin : g_chr
		assign conf_chr[i] = conf_str_i[8*(STRLEN-1-i) +: 8];
	end

	assign chr_sel = bus.byte_idx[SEL_W-1:0];
	assign in_str  = (int'(bus.byte_idx) < STRLEN);

	// ========================================================================
	// next reply byte
	// ========================================================================

	// chosen at the end of byte n and shifted out during byte n+1,
	// so string character n follows byte n
	always_comb begin
		bus.tx_byte = '0;
		case (bus.cmd)
			CMD_CONF_STR: begin
				if (in_str)
					bus.tx_byte = conf_chr[chr_sel];
			end
			default: begin
				bus.tx_byte = '0;  // write-only commands answer zero
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== host_cmd_sink.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_cmd_sink
	import user_io_pkg::*;
(
	input  logic        spi_sck,
	spi_byte_if.sink    bus,
	output but_sw_u     but_sw_o,
	output logic [31:0] joystick_0_o,
	output logic [31:0] joystick_1_o,
	output logic [63:0] status_o
);

	logic       data_byte;    // a byte after the command has just completed
	logic       first_data;
	logic       joy_range;    // data bytes 1 to 4
	logic       status_range; // data bytes 1 to 8
	logic [1:0] joy_lane;
	logic [2:0] status_lane;

	// ========================================================================
	// byte position decode
	// ========================================================================

	assign data_byte    = bus.byte_done && (bus.byte_idx != '0);
	assign first_data   = (bus.byte_idx == BYTE_IDX_W'(1));
	assign joy_range    = (bus.byte_idx < BYTE_IDX_W'(5));
	assign status_range = (bus.byte_idx < BYTE_IDX_W'(9));

	// byte 1 lands in lane 0 so the lane wraps from the top count
	assign joy_lane    = bus.byte_idx[1:0] - 2'd1;
	assign status_lane = bus.byte_idx[2:0] - 3'd1;

	// ========================================================================
	// register writes
	// ========================================================================

	// registers hold their value across frames
	always_ff @(posedge spi_sck) begin
		if (data_byte) begin
			case (bus.cmd)
				CMD_BUT_SW: begin
					if (first_data)
						but_sw_o.raw <= bus.rx_byte;
				end
				CMD_JOY0: begin
					if (joy_range)
						joystick_0_o[{joy_lane, 3'b000} +: 8] <= bus.rx_byte;
				end
				CMD_JOY1: begin
					if (joy_range)
						joystick_1_o[{joy_lane, 3'b000} +: 8] <= bus.rx_byte;
				end
				CMD_STATUS: begin
					if (status_range)
						status_o[{status_lane, 3'b000} +: 8] <= bus.rx_byte;
				end
				default: begin
					// other commands belong to other units
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== key_event_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_event_decoder
	import user_io_pkg::*;
(
	input  logic     spi_sck,
	input  logic     SPI_SS_IO,
	spi_byte_if.sink bus,
	output logic     key_strobe_o,
	output logic     key_pressed_o,
	output logic     key_extended_o,
	output byte_t    key_code_o
);

	logic cmd_byte;
	logic key_byte;
	logic is_ext;
	logic is_break;
	logic emit;
	logic ext_r;      // e0 seen since the last key
	logic pressed_r;  // cleared by f0

	assign cmd_byte = bus.byte_done && (bus.byte_idx == '0);
	assign key_byte = bus.byte_done && (bus.byte_idx != '0) && (bus.cmd == CMD_KEY);
	assign is_ext   = (bus.rx_byte == KEY_EXT_PREFIX);
	assign is_break = (bus.rx_byte == KEY_BREAK_PREFIX);
	assign emit     = key_byte && !is_ext && !is_break;

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			key_strobe_o <= 1'b0;
			ext_r        <= 1'b0;
			pressed_r    <= 1'b1;
		end else begin
			key_strobe_o <= emit;  // one cycle per scan code
			if (cmd_byte || emit) begin
				ext_r     <= 1'b0;
				pressed_r <= 1'b1;
			end else if (key_byte && is_ext) begin
				ext_r <= 1'b1;
			end else if (key_byte && is_break) begin
				pressed_r <= 1'b0;
			end
		end
	end

	// event payload, only moves together with the strobe
	always_ff @(posedge spi_sck) begin
		if (emit) begin
			key_code_o     <= bus.rx_byte;
			key_pressed_o  <= pressed_r;
			key_extended_o <= ext_r;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f user_io.f \
	--top-module tb_user_io \
	-o sim_user_io

./obj_dir/sim_user_io | tee sim.log

if grep -q "Some tests failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation clean"

// ==== spi_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if
	import user_io_pkg::*;
();
	logic                  byte_done;  // last bit of a byte is on mosi
	byte_t                 rx_byte;
	logic [BYTE_IDX_W-1:0] byte_idx;   // 0 is the command byte
	byte_t                 cmd;
	byte_t                 tx_byte;    // reply for the next byte

	modport framer (
		output byte_done,
		output rx_byte,
		output byte_idx,
		output cmd,
		input  tx_byte
	);

	modport sink (
		input byte_done,
		input rx_byte,
		input byte_idx,
		input cmd
	);

	modport reply (
		input  byte_idx,
		input  cmd,
		output tx_byte
	);

endinterface

`default_nettype wire

// ==== spi_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_frame
	import user_io_pkg::*;
(
	input  logic       spi_sck,
	input  logic       SPI_SS_IO,
	input  logic       spi_mosi_i,
	output logic       spi_miso_o,
	spi_byte_if.framer bus
);

	logic [2:0]            bit_cnt;
	logic [BYTE_IDX_W-1:0] byte_cnt;
	logic [6:0]            sbuf;      // first seven bits of the byte in flight
	byte_t                 rx_full;
	byte_t                 cmd_r;
	byte_t                 tx_shift;  // byte going out on miso

	// ========================================================================
	// receive side
	// ========================================================================

	assign rx_full = {sbuf, spi_mosi_i};  // last bit joined straight from the pin

	assign bus.byte_done = (bit_cnt == 3'd7);
	assign bus.rx_byte   = rx_full;
	assign bus.byte_idx  = byte_cnt;
	assign bus.cmd       = (byte_cnt == '0) ? rx_full : cmd_r;

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt  <= '0;
			byte_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bus.byte_done && !(&byte_cnt))
				byte_cnt <= byte_cnt + 1'b1;
		end
	end

	// mosi shift register
	always_ff @(posedge spi_sck) begin
		sbuf <= {sbuf[5:0], spi_mosi_i};
	end

	always_ff @(posedge spi_sck) begin
		if (bus.byte_done && (byte_cnt == '0))
			cmd_r <= rx_full;
	end

	// ========================================================================
	// transmit side
	// ========================================================================

	// byte 0 of every frame answers with the core type
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			tx_shift <= CORE_TYPE;
		else if (bus.byte_done)
			tx_shift <= bus.tx_byte;
	end

	// msb first with bit 7 out on the falling edge ahead of the byte
	always_ff @(negedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			spi_miso_o <= 1'b0;
		else
			spi_miso_o <= tx_shift[~bit_cnt];
	end

endmodule

`default_nettype wire

// ==== tb_user_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_user_io;
	import user_io_pkg::*;

	localparam int STRLEN = 6;
	localparam logic [8*STRLEN-1:0] CONF_STR = "CFG;O1";
	localparam int KEY_TIMEOUT = 64;  // spi_sck cycles

	logic        spi_sck;
	logic        SPI_SS_IO;
	logic        spi_mosi_i;
	logic        spi_miso_o;
	logic [1:0]  buttons_o;
	logic [1:0]  switches_o;
	logic        scandoubler_disable_o;
	logic        ypbpr_o;
	logic        no_csync_o;
	logic [31:0] joystick_0_o;
	logic [31:0] joystick_1_o;
	logic [63:0] status_o;
	logic        key_strobe_o;
	logic        key_pressed_o;
	logic        key_extended_o;
	logic [7:0]  key_code_o;

	string       conf_text = "CFG;O1";
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_errors = 0;
	byte_t       tx [$];
	byte_t       rx [$];
	logic [9:0]  key_seen [$];    // {pressed, extended, code}
	logic [9:0]  key_expect [$];
	logic [31:0] joy0_exp;
	logic [31:0] joy1_exp;
	logic [63:0] status_exp;
	byte_t       but_sw_exp;

	user_io #(
		.STRLEN (STRLEN)
	) dut_i (
		.spi_sck               (spi_sck),
		.SPI_SS_IO             (SPI_SS_IO),
		.spi_mosi_i            (spi_mosi_i),
		.conf_str_i            (CONF_STR),
		.spi_miso_o            (spi_miso_o),
		.buttons_o             (buttons_o),
		.switches_o            (switches_o),
		.scandoubler_disable_o (scandoubler_disable_o),
		.ypbpr_o               (ypbpr_o),
		.no_csync_o            (no_csync_o),
		.joystick_0_o          (joystick_0_o),
		.joystick_1_o          (joystick_1_o),
		.status_o              (status_o),
		.key_strobe_o          (key_strobe_o),
		.key_pressed_o         (key_pressed_o),
		.key_extended_o        (key_extended_o),
		.key_code_o            (key_code_o)
	);

	initial begin
		spi_sck = 1'b0;
		forever #10 spi_sck = ~spi_sck;
	end

	// key events seen on the port are sampled away from the active edge
	always @(negedge spi_sck) begin
		if (key_strobe_o)
			key_seen.push_back({key_pressed_o, key_extended_o, key_code_o});
	end

	// ========================================================================
	// helpers
	// ========================================================================

	function automatic byte_t rand_byte();
		logic [31:0] r;
		r = $urandom();
		return r[7:0];
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp)
		else begin
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
			$display("test %0d %s: FAILED", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		test_errors = 0;
	endtask

	task automatic new_frame(input byte_t cmd, input int data_bytes);
		tx.delete();
		tx.push_back(cmd);
		repeat (data_bytes) tx.push_back(rand_byte());
	endtask

	// shifts tx out msb first and collects one reply byte per byte sent
	task automatic run_frame();
		byte_t r;
		rx.delete();
		@(posedge spi_sck);
		SPI_SS_IO <= 1'b0;
		foreach (tx[i]) begin
			for (int b = 7; b >= 0; b--) begin
				spi_mosi_i <= tx[i][b];
				@(posedge spi_sck);
				r = {r[6:0], spi_miso_o};
			end
			rx.push_back(r);
		end
		spi_mosi_i <= 1'b0;
		@(posedge spi_sck);  // last key strobe goes out before deselect
		SPI_SS_IO <= 1'b1;
		repeat (3) @(posedge spi_sck);
		check_value("reply byte 0", 64'(rx[0]), 64'(CORE_TYPE));
		if (tx[0] != CMD_CONF_STR) begin
			for (int k = 1; k < rx.size(); k++)
				check_value($sformatf("reply byte %0d", k), 64'(rx[k]), 64'd0);
		end
	endtask

	// e0 marks extended, f0 marks a release, anything else is a key
	task automatic model_keys();
		logic ext;
		logic pressed;
		ext = 1'b0;
		pressed = 1'b1;
		key_expect.delete();
		for (int i = 1; i < tx.size(); i++) begin
			if (tx[i] == KEY_EXT_PREFIX) begin
				ext = 1'b1;
			end else if (tx[i] == KEY_BREAK_PREFIX) begin
				pressed = 1'b0;
			end else begin
				key_expect.push_back({pressed, ext, tx[i]});
				ext = 1'b0;
				pressed = 1'b1;
			end
		end
	endtask

	task automatic wait_key_events(input int count);
		int cycles;
		cycles = 0;
		while (key_seen.size() < count && cycles < KEY_TIMEOUT) begin
			@(posedge spi_sck);
			cycles++;
		end
		if (key_seen.size() < count) begin
			$display("timed out after %0d cycles waiting for key strobe %0d",
				cycles, key_seen.size() + 1);
			test_errors++;
		end
	endtask

	task automatic check_registers();
		check_value("buttons_o", 64'(buttons_o), 64'(but_sw_exp[1:0]));
		check_value("switches_o", 64'(switches_o), 64'(but_sw_exp[3:2]));
		check_value("scandoubler_disable_o", 64'(scandoubler_disable_o), 64'(but_sw_exp[4]));
		check_value("ypbpr_o", 64'(ypbpr_o), 64'(but_sw_exp[5]));
		check_value("no_csync_o", 64'(no_csync_o), 64'(but_sw_exp[6]));
		check_value("joystick_0_o", 64'(joystick_0_o), 64'(joy0_exp));
		check_value("joystick_1_o", 64'(joystick_1_o), 64'(joy1_exp));
		check_value("status_o", status_o, status_exp);
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin
		SPI_SS_IO <= 1'b1;
		spi_mosi_i <= 1'b0;
		void'($urandom(32'h16b1));
		repeat (4) @(posedge spi_sck);

		new_frame(8'h00, 2);  // unknown command replies core type then zeros
		run_frame();
		finish_test("core type reply");

		new_frame(CMD_BUT_SW, 1);
		run_frame();
		but_sw_exp = tx[1];
		new_frame(CMD_JOY0, 4);
		run_frame();
		joy0_exp = {tx[4], tx[3], tx[2], tx[1]};
		new_frame(CMD_JOY1, 5);  // fifth byte falls outside the joystick word
		run_frame();
		joy1_exp = {tx[4], tx[3], tx[2], tx[1]};
		new_frame(CMD_STATUS, 8);
		run_frame();
		for (int k = 8; k >= 1; k--)
			status_exp = {status_exp[55:0], tx[k]};
		check_registers();
		check_value("key strobes in write frames", 64'(key_seen.size()), 64'd0);
		finish_test("button, joystick and status writes");

		tx.delete();
		tx.push_back(CMD_KEY);
		tx.push_back(rand_byte() & 8'h7f);  // below 0x80 so never a prefix
		tx.push_back(KEY_EXT_PREFIX);
		tx.push_back(rand_byte() & 8'h7f);
		tx.push_back(KEY_BREAK_PREFIX);
		tx.push_back(rand_byte() & 8'h7f);
		tx.push_back(KEY_EXT_PREFIX);
		tx.push_back(KEY_BREAK_PREFIX);
		tx.push_back(rand_byte() & 8'h7f);
		model_keys();
		key_seen.delete();
		run_frame();
		wait_key_events(key_expect.size());
		check_value("key event count", 64'(key_seen.size()), 64'(key_expect.size()));
		foreach (key_expect[i]) begin
			if (i < key_seen.size())
				check_value($sformatf("key event %0d", i), 64'(key_seen[i]),
					64'(key_expect[i]));
		end
		finish_test("key events");

		new_frame(CMD_CONF_STR, 7);
		key_seen.delete();
		run_frame();
		for (int k = 1; k < 8; k++)
			check_value($sformatf("config reply byte %0d", k), 64'(rx[k]),
				(k <= STRLEN) ? 64'(conf_text[k-1]) : 64'd0);
		check_value("key strobes in config frame", 64'(key_seen.size()), 64'd0);
		finish_test("configuration string");

		check_registers();
		finish_test("registers hold across frames");

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_user_io_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module user_io_sva (
	input logic spi_sck,
	input logic SPI_SS_IO,
	input logic key_strobe_i,
	input logic spi_miso_i
);

	// ========================================================================
	// key event strobe
	// ========================================================================

	strobe_single_cycle: assert property (
		@(posedge spi_sck) disable iff (SPI_SS_IO)
		key_strobe_i |=> !key_strobe_i
	) else $error("key strobe high for two cycles in a row");

	strobe_idle_deselected: assert property (
		@(posedge spi_sck) SPI_SS_IO |-> !key_strobe_i
	) else $error("key strobe high while the port is deselected");

	// ========================================================================
	// miso
	// ========================================================================

	miso_idle_deselected: assert property (
		@(posedge spi_sck) SPI_SS_IO |-> !spi_miso_i
	) else $error("miso driven high while the port is deselected");

endmodule

bind user_io user_io_sva sva_i (
	.spi_sck      (spi_sck),
	.SPI_SS_IO    (SPI_SS_IO),
	.key_strobe_i (key_strobe_o),  // port level view of the strobe
	.spi_miso_i   (spi_miso_o)
);

`default_nettype wire

// ==== user_io.f ====
user_io_pkg.sv
spi_byte_if.sv
spi_frame.sv
host_cmd_sink.sv
key_event_decoder.sv
core_reply_mux.sv
user_io.sv
tb_user_io_sva.sv
tb_user_io.sv

// ==== user_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module user_io
	import user_io_pkg::*;
#(
	parameter int STRLEN = 1
)(
	input  logic                spi_sck,
	input  logic                SPI_SS_IO,
	input  logic                spi_mosi_i,
	input  logic [8*STRLEN-1:0] conf_str_i,
	output logic                spi_miso_o,

	output logic [1:0]          buttons_o,
	output logic [1:0]          switches_o,
	output logic                scandoubler_disable_o,
	output logic                ypbpr_o,
	output logic                no_csync_o,

	output logic [31:0]         joystick_0_o,
	output logic [31:0]         joystick_1_o,
	output logic [63:0]         status_o,

	output logic                key_strobe_o,
	output logic                key_pressed_o,
	output logic                key_extended_o,
	output logic [7:0]          key_code_o
);

	spi_byte_if bus_if ();

	but_sw_u but_sw;

	// ========================================================================
	// spi framing and command units
	// ========================================================================

	spi_frame u_frame (
		.spi_sck    (spi_sck),
		.SPI_SS_IO  (SPI_SS_IO),
		.spi_mosi_i (spi_mosi_i),
		.spi_miso_o (spi_miso_o),
		.bus        (bus_if)
	);

	host_cmd_sink u_sink (
		.spi_sck      (spi_sck),
		.bus          (bus_if),
		.but_sw_o     (but_sw),
		.joystick_0_o (joystick_0_o),
		.joystick_1_o (joystick_1_o),
		.status_o     (status_o)
	);

	key_event_decoder u_keys (
		.spi_sck        (spi_sck),
		.SPI_SS_IO      (SPI_SS_IO),
		.bus            (bus_if),
		.key_strobe_o   (key_strobe_o),
		.key_pressed_o  (key_pressed_o),
		.key_extended_o (key_extended_o),
		.key_code_o     (key_code_o)
	);

	core_reply_mux #(
		.STRLEN (STRLEN)
	) u_reply (
		.conf_str_i (conf_str_i),
		.bus        (bus_if)
	);

	// button/switch byte split out to the core
	assign buttons_o             = but_sw.field.buttons;
	assign switches_o            = but_sw.field.switches;
	assign scandoubler_disable_o = but_sw.field.scandoubler_disable;
	assign ypbpr_o               = but_sw.field.ypbpr;
	assign no_csync_o            = but_sw.field.no_csync;

endmodule

`default_nettype wire

// ==== user_io_pkg.sv ====
`default_nettype none

package user_io_pkg;

	// ========================================================================
	// spi byte and frame position
	// ========================================================================

	typedef logic [7:0] byte_t;

	localparam int BYTE_IDX_W = 10;  // byte position saturates at 1023

	// ========================================================================
	// host commands
	// ========================================================================

	localparam byte_t CMD_BUT_SW   = 8'h01;
	localparam byte_t CMD_KEY      = 8'h05;
	localparam byte_t CMD_CONF_STR = 8'h14;
	localparam byte_t CMD_STATUS   = 8'h1e;
	localparam byte_t CMD_JOY0     = 8'h60;
	localparam byte_t CMD_JOY1     = 8'h61;

	// ps/2 set 2 prefixes inside a key frame
	localparam byte_t KEY_EXT_PREFIX   = 8'he0;
	localparam byte_t KEY_BREAK_PREFIX = 8'hf0;

	// first reply byte of every frame
	localparam byte_t CORE_TYPE = 8'ha4;

	// ========================================================================
	// button/switch register
	// ========================================================================

	typedef struct packed {
		logic       spare;
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} but_sw_fields_t;

	// written as one byte from the spi stream, read back as fields
	typedef union packed {
		byte_t          raw;
		but_sw_fields_t field;
	} but_sw_u;

endpackage

`default_nettype wire
